// ==== compile.f ====
source/sched_pkg.sv
source/acc_type_table.sv
source/subqueue_state.sv
source/sched_fsm.sv
source/task_sched_top.sv
verif/task_sched_checker.sv
verif/tb_task_sched.sv

// ==== Makefile ====
# Verilator build and run of the task scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_task_sched
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f compile.f
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_task_sched.sv ====
// Runs with default parameters only (16 accelerators, 64 slot subqueues, 16 type entries)
`timescale 1ns/100ps
`default_nettype none

module tb_task_sched import sched_pkg::*; ();

    localparam int ACC_BITS = 4;
    localparam int SQ_BITS  = 6;
    localparam int TIMEOUT  = 200;

    logic                        clk;
    logic                        rstn;
    logic [WORD_BITS-1:0]        in_data;
    logic                        in_valid;
    logic                        in_ready;
    logic [ACC_BITS-1:0]         in_id;
    logic                        in_last;
    logic [WORD_BITS-1:0]        out_data;
    logic                        out_valid;
    logic                        out_ready;
    logic [ACC_BITS-1:0]         out_dest;
    logic [ACC_BITS+SQ_BITS-1:0] cmd_addr;
    logic                        cmd_en;
    logic                        cmd_we;
    logic [WORD_BITS-1:0]        cmd_wdata;
    logic [WORD_BITS-1:0]        cmd_rdata = '0;
    logic [ACC_BITS-1:0]         nempty_addr;
    logic                        nempty_write;
    logic                        cfg_we;
    logic [3:0]                  cfg_idx;
    logic [TASKTYPE_BITS-1:0]    cfg_type;
    logic [ACC_BITS-1:0]         cfg_first;
    logic [ACC_BITS-1:0]         cfg_count;

    logic [WORD_BITS-1:0]        mem [2**(ACC_BITS+SQ_BITS)];
    logic                        kill_en;
    logic [ACC_BITS+SQ_BITS-1:0] kill_addr;
    int                          wr_count = 0;
    logic [WORD_BITS-1:0]        args [16];
    logic [ACC_BITS-1:0]         nempty_q [$];
    int                          exp_wr [2**ACC_BITS];
    int                          exp_tid;

    task_sched_top #(
        .MAX_ACCS(16),
        .SUBQUEUE_LEN(64),
        .MAX_ACC_TYPES(16)
    ) dut (.*);

    bind task_sched_top task_sched_checker #(.DEST_BITS(ACC_BITS)) u_checker (
        .clk(clk), .rstn(rstn), .in_ready(in_ready), .out_data(out_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_dest(out_dest),
        .nempty_write(nempty_write)
    );

    always #5 clk = ~clk;

    // Command memory with registered read; the reset pattern leaves every valid bit clear
    always @(posedge clk) begin
        if (!rstn) begin
            wr_count <= 0;
            for (int i = 0; i < 2**(ACC_BITS+SQ_BITS); i++) begin
                mem[i] <= 64'(i) << 1;
            end
        end else begin
            if (cmd_en && cmd_we) begin
                mem[cmd_addr] <= cmd_wdata;
                wr_count      <= wr_count + 1;
            end
            if (cmd_en && !cmd_we) begin
                cmd_rdata <= mem[cmd_addr];
            end
            if (kill_en) begin
                mem[kill_addr][ENTRY_VALID_BIT] <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rstn && nempty_write) begin
            nempty_q.push_back(nempty_addr);
        end
        if (dut.u_checker.fail_cnt != 0) begin
            $display("A protocol assertion in the checker failed at %0t", $time);
            fail_stop();
        end
    end

    task automatic fail_stop();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic write_type(input logic [3:0] idx, input logic [7:0] ttype,
                              input logic [ACC_BITS-1:0] first,
                              input logic [ACC_BITS-1:0] count);
        cfg_we    = 1'b1;
        cfg_idx   = idx;
        cfg_type  = ttype;
        cfg_first = first;
        cfg_count = count;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic clear_valid(input logic [ACC_BITS-1:0] acc, input logic [SQ_BITS-1:0] slot);
        kill_addr = {acc, slot};
        kill_en   = 1'b1;
        @(posedge clk);
        #1;
        kill_en = 1'b0;
    endtask

    task automatic send_word(input logic [63:0] data, input bit last);
        int n;
        n        = 0;
        in_data  = data;
        in_valid = 1'b1;
        in_last  = last;
        while (!in_ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout at %0t while waiting for in_ready", $time);
                fail_stop();
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic send_msg(input logic [ACC_BITS-1:0] src, input int nargs,
                            input logic [63:0] parent, input logic [7:0] ttype,
                            input logic [7:0] inst);
        logic [63:0] w;
        in_id = src;
        w = '0;
        w[NUM_ARGS_OFFSET +: NUM_ARGS_BITS] = NUM_ARGS_BITS'(nargs);
        send_word(w, 1'b0);
        send_word(parent, 1'b0);
        w = '0;
        w[TASKTYPE_L +: TASKTYPE_BITS] = ttype;
        w[INSNUM_L +: INSNUM_BITS] = inst;
        send_word(w, nargs == 0);
        for (int i = 0; i < nargs; i++) begin
            send_word(args[i], i == nargs - 1);
        end
    endtask

    // Waits for the acknowledge, optionally stalls it for hold cycles, then takes it
    task automatic get_ack(input logic [ACC_BITS-1:0] src, input logic [7:0] code,
                           input int hold);
        int n;
        logic [63:0] held;
        n = 0;
        while (!out_valid) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout at %0t while waiting for out_valid", $time);
                fail_stop();
            end
        end
        check_eq("ack code", out_data, {56'h0, code});
        check_eq("ack dest", 64'(out_dest), 64'(src));
        held = out_data;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #1;
            check_eq("stalled out_valid", 64'(out_valid), 64'd1);
            check_eq("stalled out_data", out_data, held);
            check_eq("in_ready while stalled", 64'(in_ready), 64'd0);
        end
        out_ready = 1'b1;
        @(posedge clk);
        #1;
        out_ready = 1'b0;
        check_eq("in_ready after ack", 64'(in_ready), 64'd1);
    endtask

    task automatic check_entry(input logic [ACC_BITS-1:0] acc, input int base,
                               input int nargs, input logic [63:0] parent);
        logic [63:0] hdr;
        logic [63:0] flags;
        hdr = '0;
        hdr[ENTRY_VALID_BIT] = 1'b1;
        hdr[NUM_ARGS_OFFSET +: NUM_ARGS_BITS] = NUM_ARGS_BITS'(nargs);
        hdr[DESTID_L +: 8] = DEST_CMDOUT;
        hdr[CMD_TYPE_L +: 8] = CMD_TYPE_EXEC;
        check_eq("entry header", mem[{acc, SQ_BITS'(base)}], hdr);
        check_eq("task id", mem[{acc, SQ_BITS'(base + 1)}], {TASK_ID_PREFIX, 32'(exp_tid)});
        check_eq("parent id", mem[{acc, SQ_BITS'(base + 2)}], parent);
        for (int i = 0; i < nargs; i++) begin
            flags = '0;
            flags[ARG_IDX_L +: NUM_ARGS_BITS] = NUM_ARGS_BITS'(i);
            flags[ARG_FLAG_L +: 8] = ARG_FLAG_DEFAULT;
            check_eq("arg flags", mem[{acc, SQ_BITS'(base + 3 + 2 * i)}], flags);
            check_eq("arg word", mem[{acc, SQ_BITS'(base + 4 + 2 * i)}], args[i]);
        end
    endtask

    task automatic run_task(input logic [ACC_BITS-1:0] src, input logic [7:0] ttype,
                            input logic [7:0] inst, input int nargs, input bit ok,
                            input logic [ACC_BITS-1:0] acc, input int hold);
        logic [63:0] parent;
        int writes;
        int notes;
        parent = {$urandom(), $urandom()};
        for (int i = 0; i < nargs; i++) begin
            args[i] = {$urandom(), $urandom()};
        end
        writes = wr_count;
        notes  = nempty_q.size();
        send_msg(src, nargs, parent, ttype, inst);
        if (ok) begin
            get_ack(src, ACK_OK_CODE, hold);
            check_eq("slot writes", 64'(wr_count), 64'(writes + HDR_SLOTS + 2 * nargs));
            check_eq("notifications", 64'(nempty_q.size()), 64'(notes + 1));
            check_eq("notified acc", 64'(nempty_q[$]), 64'(acc));
            check_entry(acc, exp_wr[acc], nargs, parent);
            exp_wr[acc] = (exp_wr[acc] + HDR_SLOTS + 2 * nargs) % (2**SQ_BITS);
            exp_tid++;
        end else begin
            get_ack(src, ACK_REJECT_CODE, hold);
            check_eq("writes on reject", 64'(wr_count), 64'(writes));
            check_eq("notifications on reject", 64'(nempty_q.size()), 64'(notes));
        end
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        in_id     = '0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        cfg_we    = 1'b0;
        cfg_idx   = '0;
        cfg_type  = '0;
        cfg_first = '0;
        cfg_count = '0;
        kill_en   = 1'b0;
        kill_addr = '0;
        exp_tid   = 0;
        for (int i = 0; i < 2**ACC_BITS; i++) begin
            exp_wr[i] = 0;
        end
        void'($urandom(89112));
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;

        check_eq("out_valid after reset", 64'(out_valid), 64'd0);
        check_eq("cmd_en after reset", 64'(cmd_en), 64'd0);
        check_eq("nempty_write after reset", 64'(nempty_write), 64'd0);
        check_eq("in_ready after reset", 64'(in_ready), 64'd1);

        // Type 21h on accelerators 2 to 4, type 35h on accelerator 8 alone
        write_type(4'd0, 8'h21, 4'd2, 4'd2);
        write_type(4'd1, 8'h35, 4'd8, 4'd0);

        run_task(4'd1, 8'h21, INSNUM_ANY, 2, 1'b1, 4'd2, 0);
        run_task(4'd5, 8'h21, INSNUM_ANY, 0, 1'b1, 4'd3, 0);
        run_task(4'd9, 8'h21, INSNUM_ANY, 3, 1'b1, 4'd4, 0);
        run_task(4'd1, 8'h21, INSNUM_ANY, 1, 1'b1, 4'd2, 0);

        // Fixed instance 2, then round robin resumes there and wraps
        run_task(4'd3, 8'h21, 8'd2, 1, 1'b1, 4'd4, 0);
        run_task(4'd3, 8'h21, INSNUM_ANY, 2, 1'b1, 4'd4, 0);
        run_task(4'd3, 8'h21, INSNUM_ANY, 0, 1'b1, 4'd2, 0);

        // Three 17 slot entries fit, the fourth finds a live entry at the read index
        for (int i = 0; i < 3; i++) begin
            run_task(4'd7, 8'h35, INSNUM_ANY, 7, 1'b1, 4'd8, 0);
        end
        run_task(4'd7, 8'h35, INSNUM_ANY, 7, 1'b0, 4'd8, 0);
        clear_valid(4'd8, 6'd0);
        run_task(4'd7, 8'h35, INSNUM_ANY, 7, 1'b1, 4'd8, 0);

        run_task(4'd2, 8'h7E, INSNUM_ANY, 0, 1'b0, 4'd0, 0);

        // Task id must continue after the reject
        run_task(4'd6, 8'h21, INSNUM_ANY, 2, 1'b1, 4'd3, 4);

        repeat (3) @(posedge clk);
        if (dut.u_checker.fail_cnt == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "Protocol assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== verif/task_sched_checker.sv ====
// Protocol properties of the scheduler top level; DEST_BITS must match the accelerator id width
`timescale 1ns/100ps
`default_nettype none

module task_sched_checker import sched_pkg::*; #(
    parameter int DEST_BITS = 4
) (
    input wire                 clk,
    input wire                 rstn,
    input wire                 in_ready,
    input wire [WORD_BITS-1:0] out_data,
    input wire                 out_valid,
    input wire                 out_ready,
    input wire [DEST_BITS-1:0] out_dest,
    input wire                 nempty_write
);

    int unsigned fail_cnt = 0;

    // Acknowledge holds while the sender stalls it
    ack_hold: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_dest))
        else begin
            fail_cnt++;
            $error("acknowledge changed while stalled");
        end

    notify_then_ack: assert property (@(posedge clk) disable iff (!rstn)
        nempty_write |=> !nempty_write && out_valid)
        else begin
            fail_cnt++;
            $error("notification not a single pulse followed by the acknowledge");
        end

    ready_after_ack: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready |=> in_ready)
        else begin
            fail_cnt++;
            $error("in_ready did not return after the acknowledge");
        end

endmodule

`default_nettype wire

// ==== source/task_sched_top.sv ====
// Command memory must return read data one cycle after cmd_en; configure only while idle
`timescale 1ns/100ps
`default_nettype none

module task_sched_top import sched_pkg::*; #(
    parameter int MAX_ACCS = 16,
    parameter int SUBQUEUE_LEN = 64,
    parameter int MAX_ACC_TYPES = 16,
    localparam int ACC_BITS = $clog2(MAX_ACCS),
    localparam int SQ_BITS = $clog2(SUBQUEUE_LEN),
    localparam int TYPE_BITS = $clog2(MAX_ACC_TYPES)
) (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire  [WORD_BITS-1:0]        in_data,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire  [ACC_BITS-1:0]         in_id,
    input  wire                         in_last,
    output logic [WORD_BITS-1:0]        out_data,
    output logic                        out_valid,
    input  wire                         out_ready,
    output logic [ACC_BITS-1:0]         out_dest,
    output logic [ACC_BITS+SQ_BITS-1:0] cmd_addr,
    output logic                        cmd_en,
    output logic                        cmd_we,
    output logic [WORD_BITS-1:0]        cmd_wdata,
    input  wire  [WORD_BITS-1:0]        cmd_rdata,
    output logic [ACC_BITS-1:0]         nempty_addr,
    output logic                        nempty_write,
    input  wire                         cfg_we,
    input  wire  [TYPE_BITS-1:0]        cfg_idx,
    input  wire  [TASKTYPE_BITS-1:0]    cfg_type,
    input  wire  [ACC_BITS-1:0]         cfg_first,
    input  wire  [ACC_BITS-1:0]         cfg_count
);

    logic                     sel_start;
    logic [TASKTYPE_BITS-1:0] sel_type;
    logic [INSNUM_BITS-1:0]   sel_inst;
    logic                     sel_done;
    logic                     sel_hit;
    logic [ACC_BITS-1:0]      sel_acc;
    logic [ACC_BITS-1:0]      q_acc;
    logic [SQ_BITS-1:0]       q_rd_idx;
    logic [SQ_BITS-1:0]       q_wr_idx;
    logic [SQ_BITS:0]         q_free;
    logic                     q_upd;
    logic [SQ_BITS-1:0]       q_new_rd;
    logic [SQ_BITS-1:0]       q_new_wr;
    logic [SQ_BITS:0]         q_new_free;

    acc_type_table #(
        .MAX_ACCS(MAX_ACCS),
        .MAX_ACC_TYPES(MAX_ACC_TYPES)
    ) u_type_table (
        .clk(clk), .rstn(rstn),
        .cfg_we(cfg_we), .cfg_idx(cfg_idx), .cfg_type(cfg_type),
        .cfg_first(cfg_first), .cfg_count(cfg_count),
        .sel_start(sel_start), .sel_type(sel_type), .sel_inst(sel_inst),
        .sel_done(sel_done), .sel_hit(sel_hit), .sel_acc(sel_acc)
    );

    subqueue_state #(
        .MAX_ACCS(MAX_ACCS),
        .SUBQUEUE_LEN(SUBQUEUE_LEN)
    ) u_subqueue (
        .clk(clk), .rstn(rstn), .q_acc(q_acc),
        .q_rd_idx(q_rd_idx), .q_wr_idx(q_wr_idx), .q_free(q_free),
        .q_upd(q_upd), .q_new_rd(q_new_rd), .q_new_wr(q_new_wr), .q_new_free(q_new_free)
    );

    sched_fsm #(
        .MAX_ACCS(MAX_ACCS),
        .SUBQUEUE_LEN(SUBQUEUE_LEN)
    ) u_fsm (
        .clk(clk), .rstn(rstn),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .in_id(in_id), .in_last(in_last),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
        .out_dest(out_dest),
        .cmd_addr(cmd_addr), .cmd_en(cmd_en), .cmd_we(cmd_we),
        .cmd_wdata(cmd_wdata), .cmd_rdata(cmd_rdata),
        .nempty_addr(nempty_addr), .nempty_write(nempty_write),
        .sel_start(sel_start), .sel_type(sel_type), .sel_inst(sel_inst),
        .sel_done(sel_done), .sel_hit(sel_hit), .sel_acc(sel_acc),
        .q_acc(q_acc), .q_rd_idx(q_rd_idx), .q_wr_idx(q_wr_idx), .q_free(q_free),
        .q_upd(q_upd), .q_new_rd(q_new_rd), .q_new_wr(q_new_wr), .q_new_free(q_new_free)
    );

endmodule

`default_nettype wire

// ==== source/sched_fsm.sv ====
// Messages need at least three words and SUBQUEUE_LEN must hold a 15 argument entry (33 slots)
`timescale 1ns/100ps
`default_nettype none

module sched_fsm import sched_pkg::*; #(
    parameter int MAX_ACCS = 16,
    parameter int SUBQUEUE_LEN = 64,
    localparam int ACC_BITS = $clog2(MAX_ACCS),
    localparam int SQ_BITS = $clog2(SUBQUEUE_LEN)
) (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire  [WORD_BITS-1:0]        in_data,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire  [ACC_BITS-1:0]         in_id,
    input  wire                         in_last,
    output logic [WORD_BITS-1:0]        out_data,
    output logic                        out_valid,
    input  wire                         out_ready,
    output logic [ACC_BITS-1:0]         out_dest,
    output logic [ACC_BITS+SQ_BITS-1:0] cmd_addr,
    output logic                        cmd_en,
    output logic                        cmd_we,
    output logic [WORD_BITS-1:0]        cmd_wdata,
    input  wire  [WORD_BITS-1:0]        cmd_rdata,
    output logic [ACC_BITS-1:0]         nempty_addr,
    output logic                        nempty_write,
    output logic                        sel_start,
    output logic [TASKTYPE_BITS-1:0]    sel_type,
    output logic [INSNUM_BITS-1:0]      sel_inst,
    input  wire                         sel_done,
    input  wire                         sel_hit,
    input  wire  [ACC_BITS-1:0]         sel_acc,
    output logic [ACC_BITS-1:0]         q_acc,
    input  wire  [SQ_BITS-1:0]          q_rd_idx,
    input  wire  [SQ_BITS-1:0]          q_wr_idx,
    input  wire  [SQ_BITS:0]            q_free,
    output logic                        q_upd,
    output logic [SQ_BITS-1:0]          q_new_rd,
    output logic [SQ_BITS-1:0]          q_new_wr,
    output logic [SQ_BITS:0]            q_new_free
);

    typedef enum logic [3:0] {
        S_HDR, S_PARENT, S_TYPE, S_SEL, S_CHECK, S_RECLAIM, S_WR_TID,
        S_WR_PARENT, S_WR_FLAGS, S_WR_ARG, S_WR_HDR, S_NOTIFY, S_DRAIN, S_ACK
    } state_t;

    state_t state;
    state_t rej_state;

    logic [ACC_BITS-1:0]      src_id;
    logic [ACC_BITS-1:0]      acc;
    logic [NUM_ARGS_BITS-1:0] num_args;
    logic [NUM_ARGS_BITS-1:0] arg_cnt;
    logic [WORD_BITS-1:0]     parent_id;
    logic [31:0]              task_cnt;
    logic                     msg_done;
    logic                     ack_ok;
    logic [SQ_BITS-1:0]       rd;
    logic [SQ_BITS-1:0]       wr;
    logic [SQ_BITS-1:0]       ptr;
    logic [SQ_BITS-1:0]       slot;
    logic [SQ_BITS:0]         free;
    logic [SQ_BITS:0]         needed;
    logic [SQ_BITS:0]         rd_slots;

    assign needed   = (SQ_BITS+1)'(HDR_SLOTS) + (SQ_BITS+1)'({num_args, 1'b0});
    assign rd_slots = (SQ_BITS+1)'(HDR_SLOTS)
                    + (SQ_BITS+1)'({cmd_rdata[NUM_ARGS_OFFSET +: NUM_ARGS_BITS], 1'b0});
    // No drain needed when the type word closed the message
    assign rej_state = msg_done ? S_ACK : S_DRAIN;

    assign in_ready = (state == S_HDR) || (state == S_PARENT) || (state == S_TYPE)
                   || (state == S_WR_ARG) || (state == S_DRAIN);
    assign out_valid = state == S_ACK;
    assign out_data  = {{(WORD_BITS-8){1'b0}}, ack_ok ? ACK_OK_CODE : ACK_REJECT_CODE};
    assign out_dest  = src_id;
    assign nempty_addr = acc;

    // Record of the selected accelerator is loaded as sel_done arrives
    assign q_acc      = (state == S_SEL) ? sel_acc : acc;
    assign q_upd      = state == S_WR_HDR;
    assign q_new_rd   = rd;
    assign q_new_wr   = ptr;
    assign q_new_free = free - needed;

    assign cmd_addr = {acc, slot};

    always_comb begin
        cmd_en    = 1'b0;
        cmd_we    = 1'b0;
        slot      = ptr;
        cmd_wdata = '0;
        case (state)
            S_CHECK: begin
                cmd_en = free < needed;
                slot   = rd;
            end
            S_WR_TID: begin
                cmd_en    = 1'b1;
                cmd_we    = 1'b1;
                cmd_wdata = {TASK_ID_PREFIX, task_cnt};
            end
            S_WR_PARENT: begin
                cmd_en    = 1'b1;
                cmd_we    = 1'b1;
                cmd_wdata = parent_id;
            end
            S_WR_FLAGS: begin
                cmd_en = 1'b1;
                cmd_we = 1'b1;
                cmd_wdata[ARG_IDX_L +: NUM_ARGS_BITS] = arg_cnt;
                cmd_wdata[ARG_FLAG_L +: 8] = ARG_FLAG_DEFAULT;
            end
            S_WR_ARG: begin
                cmd_en    = in_valid;
                cmd_we    = in_valid;
                cmd_wdata = in_data;
            end
            S_WR_HDR: begin
                cmd_en = 1'b1;
                cmd_we = 1'b1;
                slot   = wr;
                cmd_wdata[ENTRY_VALID_BIT] = 1'b1;
                cmd_wdata[NUM_ARGS_OFFSET +: NUM_ARGS_BITS] = num_args;
                cmd_wdata[DESTID_L +: 8] = DEST_CMDOUT;
                cmd_wdata[CMD_TYPE_L +: 8] = CMD_TYPE_EXEC;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        sel_start    <= 1'b0;
        nempty_write <= 1'b0;
        case (state)
            S_HDR: begin
                src_id   <= in_id;
                num_args <= in_data[NUM_ARGS_OFFSET +: NUM_ARGS_BITS];
                if (in_valid) begin
                    state <= S_PARENT;
                end
            end
            S_PARENT: begin
                parent_id <= in_data;
                if (in_valid) begin
                    state <= S_TYPE;
                end
            end
            S_TYPE: begin
                sel_type <= in_data[TASKTYPE_L +: TASKTYPE_BITS];
                sel_inst <= in_data[INSNUM_L +: INSNUM_BITS];
                msg_done <= in_last;
                ack_ok   <= 1'b0;
                if (in_valid) begin
                    sel_start <= 1'b1;
                    state     <= S_SEL;
                end
            end
            S_SEL: begin
                acc  <= sel_acc;
                rd   <= q_rd_idx;
                wr   <= q_wr_idx;
                free <= q_free;
                if (sel_done) begin
                    state <= sel_hit ? S_CHECK : rej_state;
                end
            end
            S_CHECK: begin
                ptr     <= wr + 1'b1;
                arg_cnt <= '0;
                state   <= (free >= needed) ? S_WR_TID : S_RECLAIM;
            end
            S_RECLAIM: begin
                // Consumed entry at the read index frees its slots
                if (!cmd_rdata[ENTRY_VALID_BIT]) begin
                    rd    <= rd + rd_slots[SQ_BITS-1:0];
                    free  <= free + rd_slots;
                    state <= S_CHECK;
                end else begin
                    state <= rej_state;
                end
            end
            S_WR_TID: begin
                ptr   <= ptr + 1'b1;
                state <= S_WR_PARENT;
            end
            S_WR_PARENT: begin
                ptr   <= ptr + 1'b1;
                state <= (num_args == '0) ? S_WR_HDR : S_WR_FLAGS;
            end
            S_WR_FLAGS: begin
                ptr   <= ptr + 1'b1;
                state <= S_WR_ARG;
            end
            S_WR_ARG: begin
                if (in_valid) begin
                    ptr     <= ptr + 1'b1;
                    arg_cnt <= arg_cnt + 1'b1;
                    state   <= (arg_cnt == num_args - 1'b1) ? S_WR_HDR : S_WR_FLAGS;
                end
            end
            S_WR_HDR: begin
                nempty_write <= 1'b1;
                state        <= S_NOTIFY;
            end
            S_NOTIFY: begin
                task_cnt <= task_cnt + 1'b1;
                ack_ok   <= 1'b1;
                state    <= S_ACK;
            end
            S_DRAIN: begin
                if (in_valid && in_last) begin
                    state <= S_ACK;
                end
            end
            S_ACK: begin
                if (out_ready) begin
                    state <= S_HDR;
                end
            end
            default: begin
                state <= S_HDR;
            end
        endcase

        if (!rstn) begin
            state        <= S_HDR;
            task_cnt     <= '0;
            sel_start    <= 1'b0;
            nempty_write <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/subqueue_state.sv ====
// One record per accelerator, read combinationally; a single update port
`timescale 1ns/100ps
`default_nettype none

module subqueue_state #(
    parameter int MAX_ACCS = 16,
    parameter int SUBQUEUE_LEN = 64,
    localparam int ACC_BITS = $clog2(MAX_ACCS),
    localparam int SQ_BITS = $clog2(SUBQUEUE_LEN)
) (
    input  wire                clk,
    input  wire                rstn,
    input  wire  [ACC_BITS-1:0] q_acc,
    output logic [SQ_BITS-1:0] q_rd_idx,
    output logic [SQ_BITS-1:0] q_wr_idx,
    output logic [SQ_BITS:0]   q_free,
    input  wire                q_upd,
    input  wire  [SQ_BITS-1:0] q_new_rd,
    input  wire  [SQ_BITS-1:0] q_new_wr,
    input  wire  [SQ_BITS:0]   q_new_free
);

    logic [SQ_BITS-1:0] rd_idx [MAX_ACCS];
    logic [SQ_BITS-1:0] wr_idx [MAX_ACCS];
    logic [SQ_BITS:0]   free   [MAX_ACCS];

    assign q_rd_idx = rd_idx[q_acc];
    assign q_wr_idx = wr_idx[q_acc];
    assign q_free   = free[q_acc];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < MAX_ACCS; i++) begin
                rd_idx[i] <= '0;
                wr_idx[i] <= '0;
                free[i]   <= (SQ_BITS+1)'(SUBQUEUE_LEN);
            end
        end else if (q_upd) begin
            rd_idx[q_acc] <= q_new_rd;
            wr_idx[q_acc] <= q_new_wr;
            free[q_acc]   <= q_new_free;
        end
    end

endmodule

`default_nettype wire

// ==== source/acc_type_table.sv ====
// Type lookup walks one entry per cycle; sel_type and sel_inst must stay stable until sel_done
`timescale 1ns/100ps
`default_nettype none

module acc_type_table import sched_pkg::*; #(
    parameter int MAX_ACCS = 16,
    parameter int MAX_ACC_TYPES = 16,
    localparam int ACC_BITS = $clog2(MAX_ACCS),
    localparam int TYPE_BITS = $clog2(MAX_ACC_TYPES)
) (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      cfg_we,
    input  wire  [TYPE_BITS-1:0]     cfg_idx,
    input  wire  [TASKTYPE_BITS-1:0] cfg_type,
    input  wire  [ACC_BITS-1:0]      cfg_first,
    input  wire  [ACC_BITS-1:0]      cfg_count,
    input  wire                      sel_start,
    input  wire  [TASKTYPE_BITS-1:0] sel_type,
    input  wire  [INSNUM_BITS-1:0]   sel_inst,
    output logic                     sel_done,
    output logic                     sel_hit,
    output logic [ACC_BITS-1:0]      sel_acc
);

    logic [MAX_ACC_TYPES-1:0] tbl_valid;
    logic [TASKTYPE_BITS-1:0] tbl_type [MAX_ACC_TYPES];
    logic [ACC_BITS-1:0]      tbl_first[MAX_ACC_TYPES];
    logic [ACC_BITS-1:0]      tbl_count[MAX_ACC_TYPES];
    logic [ACC_BITS-1:0]      rr_cnt   [MAX_ACC_TYPES];

    logic                 scan_busy;
    logic [TYPE_BITS-1:0] scan_q;
    logic [TYPE_BITS-1:0] scan_idx;
    logic                 scan_act;
    logic                 scan_match;
    logic                 scan_last;
    logic                 sel_fixed;

    // The start cycle already looks at entry zero
    assign scan_idx   = sel_start ? '0 : scan_q;
    assign scan_act   = sel_start | scan_busy;
    assign scan_match = tbl_valid[scan_idx] && (tbl_type[scan_idx] == sel_type);
    assign scan_last  = scan_idx == TYPE_BITS'(MAX_ACC_TYPES - 1);
    assign sel_fixed  = sel_inst != INSNUM_ANY;

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            tbl_type[cfg_idx]  <= cfg_type;
            tbl_first[cfg_idx] <= cfg_first;
            tbl_count[cfg_idx] <= cfg_count;
        end
        if (scan_act) begin
            scan_q  <= scan_idx + 1'b1;
            sel_hit <= scan_match;
            sel_acc <= tbl_first[scan_idx] + (sel_fixed ? sel_inst[ACC_BITS-1:0]
                                                        : rr_cnt[scan_idx]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tbl_valid <= '0;
            scan_busy <= 1'b0;
            sel_done  <= 1'b0;
            for (int i = 0; i < MAX_ACC_TYPES; i++) begin
                rr_cnt[i] <= '0;
            end
        end else begin
            sel_done <= 1'b0;
            if (cfg_we) begin
                tbl_valid[cfg_idx] <= 1'b1;
            end
            if (scan_act) begin
                scan_busy <= !(scan_match || scan_last);
                sel_done  <= scan_match || scan_last;
            end
            if (scan_act && scan_match) begin
                // A fixed instance also moves the round-robin position
                if (sel_fixed) begin
                    rr_cnt[scan_idx] <= sel_inst[ACC_BITS-1:0];
                end else if (rr_cnt[scan_idx] == tbl_count[scan_idx]) begin
                    rr_cnt[scan_idx] <= '0;
                end else begin
                    rr_cnt[scan_idx] <= rr_cnt[scan_idx] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/sched_pkg.sv ====
// Field layout of stream and command entry words; the argument count is limited to 15
`default_nettype none

package sched_pkg;

    localparam int WORD_BITS = 64;

    // Argument count field, same place in the message header and the entry header
    localparam int NUM_ARGS_OFFSET = 8;
    localparam int NUM_ARGS_BITS   = 4;

    // Third message word
    localparam int TASKTYPE_L    = 0;
    localparam int TASKTYPE_BITS = 8;
    localparam int INSNUM_L      = 48;
    localparam int INSNUM_BITS   = 8;
    localparam logic [INSNUM_BITS-1:0] INSNUM_ANY = '1;

    // Command entry header
    localparam int ENTRY_VALID_BIT = 0;
    localparam int CMD_TYPE_L      = 56;
    localparam logic [7:0] CMD_TYPE_EXEC = 8'h01;
    localparam int DESTID_L        = 32;
    localparam logic [7:0] DEST_CMDOUT   = 8'h11;

    // Argument flags word
    localparam int ARG_IDX_L  = 8;
    localparam int ARG_FLAG_L = 0;
    localparam logic [7:0] ARG_FLAG_DEFAULT = 8'h30;

    // Header, task id and parent id, two more per argument
    localparam int HDR_SLOTS = 3;

    // Low byte of the acknowledge word
    localparam logic [7:0] ACK_OK_CODE     = 8'h01;
    localparam logic [7:0] ACK_REJECT_CODE = 8'h00;

    localparam logic [31:0] TASK_ID_PREFIX = 32'hF000_0000;

endpackage

`default_nettype wire
